/* hdl/rob_pkg.sv */
package rob_pkg;

  // Buffer and bundle sizes
  localparam int ROB_DEPTH  = 16;
  localparam int ROB_IDX_W  = 4;
  localparam int DISP_WIDTH = 2;
  localparam int WB_PORTS   = 2;
  localparam int RET_WIDTH  = 2;

  // Architectural widths
  localparam int REG_IDX_W  = 5;
  localparam int DATA_W     = 32;
  localparam int RF_RPORTS  = 2 * DISP_WIDTH;

  // One rob slot, 38 bits
  typedef struct packed {
    logic [REG_IDX_W-1:0] dest_reg;
    logic                 dest_reg_valid;
    logic [DATA_W-1:0]    result;
  } rob_entry_t;

  // Where a resolved operand came from
  typedef enum logic [1:0] {
    OPND_REGFILE     = 2'd0,
    OPND_ROB_VALUE   = 2'd1,
    OPND_ROB_PENDING = 2'd2
  } opnd_src_e;

endpackage

/* hdl/dispatch_stage.sv */
`timescale 1ns/1ps

module dispatch_stage (
  input  logic                           clock,
  input  logic                           reset_n,
  input  logic                           disp_valid_i,
  input  logic                           disp_count_i,
  input  logic [rob_pkg::REG_IDX_W-1:0]  disp_dest_i [rob_pkg::DISP_WIDTH],
  input  logic                           disp_dest_valid_i [rob_pkg::DISP_WIDTH],
  input  logic [rob_pkg::REG_IDX_W-1:0]  disp_srca_i [rob_pkg::DISP_WIDTH],
  input  logic [rob_pkg::REG_IDX_W-1:0]  disp_srcb_i [rob_pkg::DISP_WIDTH],
  input  logic                           rob_full_i,
  input  logic [rob_pkg::ROB_IDX_W-1:0]  rob_slots_i [rob_pkg::DISP_WIDTH],
  input  logic [rob_pkg::DATA_W-1:0]     rob_as_aval_i [rob_pkg::DISP_WIDTH],
  input  logic                           rob_as_avalid_i [rob_pkg::DISP_WIDTH],
  input  logic                           rob_as_apresent_i [rob_pkg::DISP_WIDTH],
  input  logic [rob_pkg::DATA_W-1:0]     rob_as_bval_i [rob_pkg::DISP_WIDTH],
  input  logic                           rob_as_bvalid_i [rob_pkg::DISP_WIDTH],
  input  logic                           rob_as_bpresent_i [rob_pkg::DISP_WIDTH],
  input  logic [rob_pkg::DATA_W-1:0]     rf_rdata_i [rob_pkg::RF_RPORTS],
  output logic                           rob_reserve_o,
  output logic                           rob_reserve_count_o,
  output logic [rob_pkg::ROB_IDX_W-1:0]  rob_as_idx_o [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::REG_IDX_W-1:0]  rob_as_areg_o [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::REG_IDX_W-1:0]  rob_as_breg_o [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::REG_IDX_W-1:0]  rf_raddr_o [rob_pkg::RF_RPORTS],
  input  logic                           flush_i,
  output logic                           dispatch_ready_o,
  output logic                           issue_valid_o [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::ROB_IDX_W-1:0]  issue_slot_o [rob_pkg::DISP_WIDTH],
  output rob_pkg::opnd_src_e             issue_srca_kind_o [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::DATA_W-1:0]     issue_srca_o [rob_pkg::DISP_WIDTH],
  output rob_pkg::opnd_src_e             issue_srcb_kind_o [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::DATA_W-1:0]     issue_srcb_o [rob_pkg::DISP_WIDTH]
);
  import rob_pkg::*;

  logic              accept;
  opnd_src_e         kind_a [DISP_WIDTH];
  opnd_src_e         kind_b [DISP_WIDTH];
  logic [DATA_W-1:0] opnd_a [DISP_WIDTH];
  logic [DATA_W-1:0] opnd_b [DISP_WIDTH];

  // In-bundle producer first, then the rob, then committed state
  function automatic void resolve(
    input  int                   lane,
    input  logic [REG_IDX_W-1:0] src,
    input  logic [DATA_W-1:0]    rob_val,
    input  logic                 rob_valid,
    input  logic                 rob_present,
    input  logic [DATA_W-1:0]    rf_val,
    output opnd_src_e            kind,
    output logic [DATA_W-1:0]    opnd
  );
    if (lane > 0 && disp_dest_valid_i[0] && disp_dest_i[0] == src) begin
      kind = OPND_ROB_PENDING;
      opnd = DATA_W'(rob_slots_i[0]);
    end else if (rob_present) begin
      kind = rob_valid ? OPND_ROB_VALUE : OPND_ROB_PENDING;
      opnd = rob_val;
    end else begin
      kind = OPND_REGFILE;
      opnd = rf_val;
    end
  endfunction

  assign dispatch_ready_o    = !rob_full_i;
  assign accept              = disp_valid_i && dispatch_ready_o && !flush_i;
  assign rob_reserve_o       = accept;
  assign rob_reserve_count_o = disp_count_i;

  always_comb begin
    for (int i = 0; i < DISP_WIDTH; i++) begin
      rob_as_idx_o[i]      = rob_slots_i[i];
      rob_as_areg_o[i]     = disp_srca_i[i];
      rob_as_breg_o[i]     = disp_srcb_i[i];
      rf_raddr_o[2*i]      = disp_srca_i[i];
      rf_raddr_o[2*i+1]    = disp_srcb_i[i];
      resolve(i, disp_srca_i[i], rob_as_aval_i[i], rob_as_avalid_i[i],
              rob_as_apresent_i[i], rf_rdata_i[2*i], kind_a[i], opnd_a[i]);
      resolve(i, disp_srcb_i[i], rob_as_bval_i[i], rob_as_bvalid_i[i],
              rob_as_bpresent_i[i], rf_rdata_i[2*i+1], kind_b[i], opnd_b[i]);
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < DISP_WIDTH; i++) begin
        issue_valid_o[i] <= 1'b0;
      end
    end else begin
      issue_valid_o[0] <= accept;
      issue_valid_o[1] <= accept && disp_count_i;
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < DISP_WIDTH; i++) begin
      issue_slot_o[i]      <= rob_slots_i[i];
      issue_srca_kind_o[i] <= kind_a[i];
      issue_srca_o[i]      <= opnd_a[i];
      issue_srcb_kind_o[i] <= kind_b[i];
      issue_srcb_o[i]      <= opnd_b[i];
    end
  end

  // Both lanes of a bundle get back-to-back slots
  a_slots_consecutive: assert property (@(posedge clock) disable iff (!reset_n)
    rob_reserve_o |-> (rob_slots_i[1] == rob_slots_i[0] + ROB_IDX_W'(1)));

endmodule

/* hdl/rob.sv */
`timescale 1ns/1ps

module rob (
  input  logic                           clock,
  input  logic                           reset_n,
  input  logic                           reserve_i,
  input  logic                           reserve_count_i,
  input  logic [rob_pkg::REG_IDX_W-1:0]  dest_reg_i [rob_pkg::DISP_WIDTH],
  input  logic                           dest_reg_valid_i [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::ROB_IDX_W-1:0]  reserved_slots_o [rob_pkg::DISP_WIDTH],
  output logic                           full_o,
  input  logic [rob_pkg::ROB_IDX_W-1:0]  as_query_idx_i [rob_pkg::DISP_WIDTH],
  input  logic [rob_pkg::REG_IDX_W-1:0]  as_areg_i [rob_pkg::DISP_WIDTH],
  input  logic [rob_pkg::REG_IDX_W-1:0]  as_breg_i [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::DATA_W-1:0]     as_aval_o [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::DATA_W-1:0]     as_bval_o [rob_pkg::DISP_WIDTH],
  output logic                           as_aval_valid_o [rob_pkg::DISP_WIDTH],
  output logic                           as_bval_valid_o [rob_pkg::DISP_WIDTH],
  output logic                           as_aval_present_o [rob_pkg::DISP_WIDTH],
  output logic                           as_bval_present_o [rob_pkg::DISP_WIDTH],
  input  logic                           write_valid_i [rob_pkg::WB_PORTS],
  input  logic [rob_pkg::ROB_IDX_W-1:0]  write_slot_i [rob_pkg::WB_PORTS],
  input  logic [rob_pkg::DATA_W-1:0]     write_data_i [rob_pkg::WB_PORTS],
  input  logic                           consume_i,
  input  logic                           consume_count_i,
  output rob_pkg::rob_entry_t            slot_data_o [rob_pkg::RET_WIDTH],
  output logic                           slot_valid_o [rob_pkg::RET_WIDTH],
  output logic [rob_pkg::ROB_IDX_W-1:0]  head_slot_o,
  output logic                           empty_o,
  input  logic                           flush_i,
  input  logic [rob_pkg::ROB_IDX_W-1:0]  flush_idx_i,
  output logic [rob_pkg::ROB_IDX_W:0]    used_count_o
);
  import rob_pkg::*;

  rob_entry_t             buffer [ROB_DEPTH];
  logic [ROB_DEPTH-1:0]   complete;
  logic [ROB_IDX_W-1:0]   ins_ptr;
  logic [ROB_IDX_W-1:0]   ext_ptr;
  logic [ROB_IDX_W:0]     n_res;
  logic [ROB_IDX_W:0]     n_con;
  logic [ROB_IDX_W:0]     n_drop;
  logic [DATA_W+1:0]      hit_a [DISP_WIDTH];
  logic [DATA_W+1:0]      hit_b [DISP_WIDTH];

  // Youngest occupied entry older than the query slot that writes src.
  // Returns {present, complete, value}; a pending hit carries its slot as value.
  function automatic logic [DATA_W+1:0] lookup(
    input logic [ROB_IDX_W-1:0] query,
    input logic [REG_IDX_W-1:0] src
  );
    logic [ROB_IDX_W-1:0] k;
    logic [ROB_IDX_W-1:0] age;
    logic [ROB_IDX_W-1:0] qdist;
    logic [DATA_W+1:0]    res;
    qdist = query - ext_ptr;
    res   = '0;
    for (int d = 1; d < ROB_DEPTH; d++) begin
      k   = query - ROB_IDX_W'(d);
      age = k - ext_ptr;
      if (!res[DATA_W+1] && age < qdist && {1'b0, age} < used_count_o &&
          buffer[k].dest_reg_valid && buffer[k].dest_reg == src) begin
        res = {1'b1, complete[k],
               complete[k] ? buffer[k].result : DATA_W'(k)};
      end
    end
    return res;
  endfunction

  always_comb begin
    for (int i = 0; i < DISP_WIDTH; i++) begin
      reserved_slots_o[i]  = ins_ptr + ROB_IDX_W'(i);
      hit_a[i]             = lookup(as_query_idx_i[i], as_areg_i[i]);
      hit_b[i]             = lookup(as_query_idx_i[i], as_breg_i[i]);
      as_aval_present_o[i] = hit_a[i][DATA_W+1];
      as_aval_valid_o[i]   = hit_a[i][DATA_W];
      as_aval_o[i]         = hit_a[i][DATA_W-1:0];
      as_bval_present_o[i] = hit_b[i][DATA_W+1];
      as_bval_valid_o[i]   = hit_b[i][DATA_W];
      as_bval_o[i]         = hit_b[i][DATA_W-1:0];
    end
    for (int i = 0; i < RET_WIDTH; i++) begin
      slot_data_o[i]  = buffer[ext_ptr + ROB_IDX_W'(i)];
      slot_valid_o[i] = complete[ext_ptr + ROB_IDX_W'(i)];
    end
  end

  assign n_res  = reserve_i ? (ROB_IDX_W+1)'(reserve_count_i) + 1'b1 : '0;
  assign n_con  = consume_i ? (ROB_IDX_W+1)'(consume_count_i) + 1'b1 : '0;
  // Entries younger than the delay slot
  assign n_drop = {1'b0, ROB_IDX_W'(ins_ptr - flush_idx_i - 2'd2)};

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      ins_ptr      <= '0;
      ext_ptr      <= '0;
      used_count_o <= '0;
    end else begin
      if (consume_i) begin
        ext_ptr <= ext_ptr + ROB_IDX_W'(n_con);
      end
      if (flush_i) begin
        ins_ptr      <= flush_idx_i + 2'd2;
        used_count_o <= used_count_o - n_drop - n_con;
      end else begin
        ins_ptr      <= ins_ptr + ROB_IDX_W'(n_res);
        used_count_o <= used_count_o + n_res - n_con;
      end
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      complete <= '0;
    end else begin
      for (int i = 0; i < DISP_WIDTH; i++) begin
        if (reserve_i && i <= int'(reserve_count_i)) begin
          complete[reserved_slots_o[i]] <= 1'b0;
        end
      end
      for (int p = 0; p < WB_PORTS; p++) begin
        if (write_valid_i[p]) begin
          complete[write_slot_i[p]] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < DISP_WIDTH; i++) begin
      if (reserve_i && i <= int'(reserve_count_i)) begin
        buffer[reserved_slots_o[i]].dest_reg       <= dest_reg_i[i];
        buffer[reserved_slots_o[i]].dest_reg_valid <= dest_reg_valid_i[i];
      end
    end
    for (int p = 0; p < WB_PORTS; p++) begin
      if (write_valid_i[p]) begin
        buffer[write_slot_i[p]].result <= write_data_i[p];
      end
    end
  end

  assign head_slot_o = ext_ptr;
  assign empty_o     = (used_count_o == '0);
  assign full_o      = (used_count_o > (ROB_IDX_W+1)'(ROB_DEPTH - DISP_WIDTH));

  // Results only land in slots between head and tail
  for (genvar p = 0; p < WB_PORTS; p++) begin : g_write_chk
    a_write_occupied: assert property (@(posedge clock) disable iff (!reset_n)
      write_valid_i[p] |-> ({1'b0, ROB_IDX_W'(write_slot_i[p] - ext_ptr)} < used_count_o));
  end

  a_consume_bound: assert property (@(posedge clock) disable iff (!reset_n)
    consume_i |-> (n_con <= used_count_o));

endmodule

/* hdl/retire_stage.sv */
`timescale 1ns/1ps

module retire_stage (
  input  logic                           clock,
  input  logic                           reset_n,
  input  rob_pkg::rob_entry_t            slot_data_i [rob_pkg::RET_WIDTH],
  input  logic                           slot_valid_i [rob_pkg::RET_WIDTH],
  input  logic                           empty_i,
  input  logic [rob_pkg::ROB_IDX_W:0]    used_count_i,
  input  logic [rob_pkg::ROB_IDX_W-1:0]  head_slot_i,
  output logic                           consume_o,
  output logic                           consume_count_o,
  output logic                           rf_we_o [rob_pkg::RET_WIDTH],
  output logic [rob_pkg::REG_IDX_W-1:0]  rf_waddr_o [rob_pkg::RET_WIDTH],
  output logic [rob_pkg::DATA_W-1:0]     rf_wdata_o [rob_pkg::RET_WIDTH],
  output logic                           retire_valid_o [rob_pkg::RET_WIDTH],
  output logic [rob_pkg::ROB_IDX_W-1:0]  retire_slot_o [rob_pkg::RET_WIDTH],
  output logic [rob_pkg::REG_IDX_W-1:0]  retire_reg_o [rob_pkg::RET_WIDTH],
  output logic [rob_pkg::DATA_W-1:0]     retire_data_o [rob_pkg::RET_WIDTH]
);
  import rob_pkg::*;

  logic [RET_WIDTH-1:0] ret;
  logic                 run;

  // Contiguous run of completed entries from the head
  always_comb begin
    run = !empty_i;
    for (int i = 0; i < RET_WIDTH; i++) begin
      run    = run && slot_valid_i[i] && (used_count_i > (ROB_IDX_W+1)'(i));
      ret[i] = run;
    end
  end

  assign consume_o       = ret[0];
  assign consume_count_o = ret[1];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < RET_WIDTH; i++) begin
        retire_valid_o[i] <= 1'b0;
        rf_we_o[i]        <= 1'b0;
      end
    end else begin
      for (int i = 0; i < RET_WIDTH; i++) begin
        retire_valid_o[i] <= ret[i];
        rf_we_o[i]        <= ret[i] && slot_data_i[i].dest_reg_valid;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < RET_WIDTH; i++) begin
      retire_slot_o[i] <= head_slot_i + ROB_IDX_W'(i);
      retire_reg_o[i]  <= slot_data_i[i].dest_reg;
      retire_data_o[i] <= slot_data_i[i].result;
      rf_waddr_o[i]    <= slot_data_i[i].dest_reg;
      rf_wdata_o[i]    <= slot_data_i[i].result;
    end
  end

endmodule

/* hdl/arch_regfile.sv */
`timescale 1ns/1ps

module arch_regfile (
  input  logic                           clock,
  input  logic                           reset_n,
  input  logic [rob_pkg::REG_IDX_W-1:0]  raddr_i [rob_pkg::RF_RPORTS],
  output logic [rob_pkg::DATA_W-1:0]     rdata_o [rob_pkg::RF_RPORTS],
  input  logic                           we_i [rob_pkg::RET_WIDTH],
  input  logic [rob_pkg::REG_IDX_W-1:0]  waddr_i [rob_pkg::RET_WIDTH],
  input  logic [rob_pkg::DATA_W-1:0]     wdata_i [rob_pkg::RET_WIDTH]
);
  import rob_pkg::*;

  logic [DATA_W-1:0] regs [2**REG_IDX_W];

  // Later lane wins on a same-register write
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int r = 0; r < 2**REG_IDX_W; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int w = 0; w < RET_WIDTH; w++) begin
        if (we_i[w] && waddr_i[w] != '0) begin
          regs[waddr_i[w]] <= wdata_i[w];
        end
      end
    end
  end

  // Write-through, so a just-retired value is visible to dispatch at once
  always_comb begin
    for (int p = 0; p < RF_RPORTS; p++) begin
      rdata_o[p] = regs[raddr_i[p]];
      for (int w = 0; w < RET_WIDTH; w++) begin
        if (we_i[w] && waddr_i[w] == raddr_i[p] && raddr_i[p] != '0) begin
          rdata_o[p] = wdata_i[w];
        end
      end
    end
  end

endmodule

/* hdl/rob_core_top.sv */
`timescale 1ns/1ps

module rob_core_top (
  input  logic                           clock,
  input  logic                           reset_n,
  input  logic                           disp_valid_i,
  input  logic                           disp_count_i,
  input  logic [rob_pkg::REG_IDX_W-1:0]  disp_dest_i [rob_pkg::DISP_WIDTH],
  input  logic                           disp_dest_valid_i [rob_pkg::DISP_WIDTH],
  input  logic [rob_pkg::REG_IDX_W-1:0]  disp_srca_i [rob_pkg::DISP_WIDTH],
  input  logic [rob_pkg::REG_IDX_W-1:0]  disp_srcb_i [rob_pkg::DISP_WIDTH],
  output logic                           dispatch_ready_o,
  output logic                           issue_valid_o [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::ROB_IDX_W-1:0]  issue_slot_o [rob_pkg::DISP_WIDTH],
  output rob_pkg::opnd_src_e             issue_srca_kind_o [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::DATA_W-1:0]     issue_srca_o [rob_pkg::DISP_WIDTH],
  output rob_pkg::opnd_src_e             issue_srcb_kind_o [rob_pkg::DISP_WIDTH],
  output logic [rob_pkg::DATA_W-1:0]     issue_srcb_o [rob_pkg::DISP_WIDTH],
  input  logic                           wb_valid_i [rob_pkg::WB_PORTS],
  input  logic [rob_pkg::ROB_IDX_W-1:0]  wb_slot_i [rob_pkg::WB_PORTS],
  input  logic [rob_pkg::DATA_W-1:0]     wb_data_i [rob_pkg::WB_PORTS],
  input  logic                           flush_i,
  input  logic [rob_pkg::ROB_IDX_W-1:0]  flush_idx_i,
  output logic                           retire_valid_o [rob_pkg::RET_WIDTH],
  output logic [rob_pkg::ROB_IDX_W-1:0]  retire_slot_o [rob_pkg::RET_WIDTH],
  output logic [rob_pkg::REG_IDX_W-1:0]  retire_reg_o [rob_pkg::RET_WIDTH],
  output logic [rob_pkg::DATA_W-1:0]     retire_data_o [rob_pkg::RET_WIDTH],
  output logic                           rob_empty_o
);
  import rob_pkg::*;

  logic                 reserve, reserve_count, rob_full;
  logic [ROB_IDX_W-1:0] rob_slots [DISP_WIDTH];
  logic [ROB_IDX_W-1:0] as_idx [DISP_WIDTH];
  logic [REG_IDX_W-1:0] as_areg [DISP_WIDTH];
  logic [REG_IDX_W-1:0] as_breg [DISP_WIDTH];
  logic [DATA_W-1:0]    as_aval [DISP_WIDTH];
  logic [DATA_W-1:0]    as_bval [DISP_WIDTH];
  logic                 as_avalid [DISP_WIDTH];
  logic                 as_bvalid [DISP_WIDTH];
  logic                 as_apresent [DISP_WIDTH];
  logic                 as_bpresent [DISP_WIDTH];
  logic [REG_IDX_W-1:0] rf_raddr [RF_RPORTS];
  logic [DATA_W-1:0]    rf_rdata [RF_RPORTS];
  rob_entry_t           head_data [RET_WIDTH];
  logic                 head_valid [RET_WIDTH];
  logic [ROB_IDX_W-1:0] head_slot;
  logic [ROB_IDX_W:0]   used_count;
  logic                 consume, consume_count;
  logic                 rf_we [RET_WIDTH];
  logic [REG_IDX_W-1:0] rf_waddr [RET_WIDTH];
  logic [DATA_W-1:0]    rf_wdata [RET_WIDTH];

  dispatch_stage u_dispatch_stage (
    .clock, .reset_n, .disp_valid_i, .disp_count_i, .disp_dest_i, .disp_dest_valid_i,
    .disp_srca_i, .disp_srcb_i,
    .rob_full_i(rob_full), .rob_slots_i(rob_slots),
    .rob_as_aval_i(as_aval), .rob_as_avalid_i(as_avalid), .rob_as_apresent_i(as_apresent),
    .rob_as_bval_i(as_bval), .rob_as_bvalid_i(as_bvalid), .rob_as_bpresent_i(as_bpresent),
    .rf_rdata_i(rf_rdata), .rob_reserve_o(reserve), .rob_reserve_count_o(reserve_count),
    .rob_as_idx_o(as_idx), .rob_as_areg_o(as_areg), .rob_as_breg_o(as_breg),
    .rf_raddr_o(rf_raddr), .flush_i, .dispatch_ready_o,
    .issue_valid_o, .issue_slot_o, .issue_srca_kind_o, .issue_srca_o,
    .issue_srcb_kind_o, .issue_srcb_o
  );

  rob u_rob (
    .clock, .reset_n, .reserve_i(reserve), .reserve_count_i(reserve_count),
    .dest_reg_i(disp_dest_i), .dest_reg_valid_i(disp_dest_valid_i),
    .reserved_slots_o(rob_slots), .full_o(rob_full),
    .as_query_idx_i(as_idx), .as_areg_i(as_areg), .as_breg_i(as_breg),
    .as_aval_o(as_aval), .as_bval_o(as_bval),
    .as_aval_valid_o(as_avalid), .as_bval_valid_o(as_bvalid),
    .as_aval_present_o(as_apresent), .as_bval_present_o(as_bpresent),
    .write_valid_i(wb_valid_i), .write_slot_i(wb_slot_i), .write_data_i(wb_data_i),
    .consume_i(consume), .consume_count_i(consume_count),
    .slot_data_o(head_data), .slot_valid_o(head_valid), .head_slot_o(head_slot),
    .empty_o(rob_empty_o), .flush_i, .flush_idx_i, .used_count_o(used_count)
  );

  retire_stage u_retire_stage (
    .clock, .reset_n, .slot_data_i(head_data), .slot_valid_i(head_valid),
    .empty_i(rob_empty_o), .used_count_i(used_count), .head_slot_i(head_slot),
    .consume_o(consume), .consume_count_o(consume_count),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .retire_valid_o, .retire_slot_o, .retire_reg_o, .retire_data_o
  );

  arch_regfile u_arch_regfile (
    .clock, .reset_n, .raddr_i(rf_raddr), .rdata_o(rf_rdata),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
  );

endmodule

/* sim/rob_tb.sv */
`timescale 1ns/1ps

module rob_tb;
  import rob_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_CYCLES = 1500;
  localparam int PHASE_LEN  = 150;
  localparam int MARGIN     = 200;

  // One in-flight instruction as the model sees it
  typedef struct packed {
    logic [ROB_IDX_W-1:0] slot;
    logic [REG_IDX_W-1:0] dest;
    logic                 dest_valid;
    logic [DATA_W-1:0]    value;
    logic                 done;
  } entry_t;

  logic                 clock;
  logic                 reset_n;
  logic                 disp_valid;
  logic                 disp_count;
  logic [REG_IDX_W-1:0] disp_dest [DISP_WIDTH];
  logic                 disp_dest_valid [DISP_WIDTH];
  logic [REG_IDX_W-1:0] disp_srca [DISP_WIDTH];
  logic [REG_IDX_W-1:0] disp_srcb [DISP_WIDTH];
  logic                 dispatch_ready;
  logic                 issue_valid [DISP_WIDTH];
  logic [ROB_IDX_W-1:0] issue_slot [DISP_WIDTH];
  opnd_src_e            issue_srca_kind [DISP_WIDTH];
  logic [DATA_W-1:0]    issue_srca [DISP_WIDTH];
  opnd_src_e            issue_srcb_kind [DISP_WIDTH];
  logic [DATA_W-1:0]    issue_srcb [DISP_WIDTH];
  logic                 wb_valid [WB_PORTS];
  logic [ROB_IDX_W-1:0] wb_slot [WB_PORTS];
  logic [DATA_W-1:0]    wb_data [WB_PORTS];
  logic                 flush;
  logic [ROB_IDX_W-1:0] flush_idx;
  logic                 retire_valid [RET_WIDTH];
  logic [ROB_IDX_W-1:0] retire_slot [RET_WIDTH];
  logic [REG_IDX_W-1:0] retire_reg [RET_WIDTH];
  logic [DATA_W-1:0]    retire_data [RET_WIDTH];
  logic                 rob_empty;

  // Reference model
  entry_t               rob_q [$];
  logic [DATA_W-1:0]    creg [2**REG_IDX_W];
  logic [ROB_IDX_W-1:0] tail_slot;
  logic                 bundle_taken;
  logic                 checks_on;
  logic [31:0]          lfsr;
  int                   checks;
  int                   errors;

  // Expected outputs for the cycle after the last edge
  logic                 exp_issue_valid [DISP_WIDTH];
  logic [ROB_IDX_W-1:0] exp_issue_slot [DISP_WIDTH];
  logic [1:0]           exp_a_kind [DISP_WIDTH];
  logic [DATA_W-1:0]    exp_a_val [DISP_WIDTH];
  logic [1:0]           exp_b_kind [DISP_WIDTH];
  logic [DATA_W-1:0]    exp_b_val [DISP_WIDTH];
  logic                 exp_ret_valid [RET_WIDTH];
  entry_t               exp_ret [RET_WIDTH];

  rob_core_top u_dut (
    .clock(clock), .reset_n(reset_n),
    .disp_valid_i(disp_valid), .disp_count_i(disp_count),
    .disp_dest_i(disp_dest), .disp_dest_valid_i(disp_dest_valid),
    .disp_srca_i(disp_srca), .disp_srcb_i(disp_srcb),
    .dispatch_ready_o(dispatch_ready),
    .issue_valid_o(issue_valid), .issue_slot_o(issue_slot),
    .issue_srca_kind_o(issue_srca_kind), .issue_srca_o(issue_srca),
    .issue_srcb_kind_o(issue_srcb_kind), .issue_srcb_o(issue_srcb),
    .wb_valid_i(wb_valid), .wb_slot_i(wb_slot), .wb_data_i(wb_data),
    .flush_i(flush), .flush_idx_i(flush_idx),
    .retire_valid_o(retire_valid), .retire_slot_o(retire_slot),
    .retire_reg_o(retire_reg), .retire_data_o(retire_data),
    .rob_empty_o(rob_empty)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h, expected %h", $time, name, got, expected);
    end
  endtask

  // Youngest older producer wins; in-bundle producer overrides the rest
  function automatic void resolve_operand(
    input  logic [REG_IDX_W-1:0] src,
    input  logic                 in_bundle_hit,
    output logic [1:0]           kind,
    output logic [DATA_W-1:0]    value
  );
    kind  = OPND_REGFILE;
    value = creg[src];
    for (int i = 0; i < rob_q.size(); i++) begin
      if (rob_q[i].dest_valid && rob_q[i].dest == src) begin
        kind  = rob_q[i].done ? OPND_ROB_VALUE : OPND_ROB_PENDING;
        value = rob_q[i].done ? rob_q[i].value : DATA_W'(rob_q[i].slot);
      end
    end
    if (in_bundle_hit) begin
      kind  = OPND_ROB_PENDING;
      value = DATA_W'(tail_slot);
    end
  endfunction

  // Completed entries from the head that leave at the next edge
  function automatic int retire_run_len();
    int run;
    run = 0;
    for (int i = 0; i < RET_WIDTH; i++) begin
      if (run == i && i < rob_q.size() && rob_q[i].done) begin
        run++;
      end
    end
    return run;
  endfunction

  task automatic model_step();
    logic   hit;
    int     run;
    int     keep;
    entry_t e;
    bundle_taken = disp_valid && (rob_q.size() <= ROB_DEPTH - DISP_WIDTH) && !flush;
    for (int i = 0; i < DISP_WIDTH; i++) begin
      exp_issue_valid[i] = bundle_taken && (i == 0 || disp_count);
      exp_issue_slot[i]  = tail_slot + ROB_IDX_W'(i);
      hit = (i > 0) && disp_dest_valid[0] && disp_dest[0] == disp_srca[i];
      resolve_operand(disp_srca[i], hit, exp_a_kind[i], exp_a_val[i]);
      hit = (i > 0) && disp_dest_valid[0] && disp_dest[0] == disp_srcb[i];
      resolve_operand(disp_srcb[i], hit, exp_b_kind[i], exp_b_val[i]);
    end
    run = retire_run_len();
    for (int i = 0; i < RET_WIDTH; i++) begin
      exp_ret_valid[i] = (i < run);
      if (i < run) begin
        exp_ret[i] = rob_q[i];
      end
    end
    for (int p = 0; p < WB_PORTS; p++) begin
      for (int i = 0; i < rob_q.size(); i++) begin
        if (wb_valid[p] && rob_q[i].slot == wb_slot[p]) begin
          e       = rob_q[i];
          e.done  = 1'b1;
          e.value = wb_data[p];
          rob_q[i] = e;
        end
      end
    end
    // Branch and delay slot stay
    if (flush) begin
      keep = rob_q.size();
      for (int i = 0; i < rob_q.size(); i++) begin
        if (rob_q[i].slot == flush_idx) begin
          keep = i + 2;
        end
      end
      while (rob_q.size() > keep) begin
        e = rob_q.pop_back();
      end
      tail_slot = flush_idx + ROB_IDX_W'(2);
    end
    for (int i = 0; i < run; i++) begin
      e = rob_q.pop_front();
      if (e.dest_valid && e.dest != '0) begin
        creg[e.dest] = e.value;
      end
    end
    if (bundle_taken) begin
      for (int i = 0; i <= int'(disp_count); i++) begin
        e.slot       = tail_slot + ROB_IDX_W'(i);
        e.dest       = disp_dest[i];
        e.dest_valid = disp_dest_valid[i];
        e.value      = '0;
        e.done       = 1'b0;
        rob_q.push_back(e);
      end
      tail_slot = tail_slot + ROB_IDX_W'(1) + ROB_IDX_W'(disp_count);
    end
  endtask

  task automatic compare_outputs();
    for (int i = 0; i < DISP_WIDTH; i++) begin
      check_value($sformatf("issue_valid_o[%0d]", i), 32'(issue_valid[i]),
                  32'(exp_issue_valid[i]));
      if (exp_issue_valid[i]) begin
        check_value($sformatf("issue_slot_o[%0d]", i), 32'(issue_slot[i]),
                    32'(exp_issue_slot[i]));
        check_value($sformatf("issue_srca_kind_o[%0d]", i), 32'(issue_srca_kind[i]),
                    32'(exp_a_kind[i]));
        check_value($sformatf("issue_srca_o[%0d]", i), issue_srca[i], exp_a_val[i]);
        check_value($sformatf("issue_srcb_kind_o[%0d]", i), 32'(issue_srcb_kind[i]),
                    32'(exp_b_kind[i]));
        check_value($sformatf("issue_srcb_o[%0d]", i), issue_srcb[i], exp_b_val[i]);
      end
    end
    for (int i = 0; i < RET_WIDTH; i++) begin
      check_value($sformatf("retire_valid_o[%0d]", i), 32'(retire_valid[i]),
                  32'(exp_ret_valid[i]));
      if (exp_ret_valid[i]) begin
        check_value($sformatf("retire_slot_o[%0d]", i), 32'(retire_slot[i]),
                    32'(exp_ret[i].slot));
        check_value($sformatf("retire_reg_o[%0d]", i), 32'(retire_reg[i]),
                    32'(exp_ret[i].dest));
        check_value($sformatf("retire_data_o[%0d]", i), retire_data[i], exp_ret[i].value);
      end
    end
    check_value("dispatch_ready_o", 32'(dispatch_ready),
                32'(rob_q.size() <= ROB_DEPTH - DISP_WIDTH));
    check_value("rob_empty_o", 32'(rob_empty), 32'(rob_q.size() == 0));
  endtask

  task automatic drive_inputs(input logic new_bundles, input logic flushes,
                              input int write_rate);
    int open_q [$];
    int n;
    // A refused bundle is held unchanged
    if (!(disp_valid && !bundle_taken)) begin
      disp_valid = new_bundles && (rand_bits(2) != 0);
      disp_count = (rand_bits(1) != 0);
      for (int i = 0; i < DISP_WIDTH; i++) begin
        disp_dest[i]       = REG_IDX_W'(rand_bits(3) + 1);
        disp_dest_valid[i] = (rand_bits(2) != 0);
        disp_srca[i]       = REG_IDX_W'(rand_bits(3));
        disp_srcb[i]       = REG_IDX_W'(rand_bits(3));
      end
    end
    for (int i = 0; i < rob_q.size(); i++) begin
      if (!rob_q[i].done) begin
        open_q.push_back(i);
      end
    end
    // Results come back in random order
    for (int p = 0; p < WB_PORTS; p++) begin
      wb_valid[p] = 1'b0;
      if (open_q.size() > 0 && int'(rand_bits(3)) < write_rate) begin
        n           = int'(rand_bits(5)) % open_q.size();
        wb_valid[p] = 1'b1;
        wb_slot[p]  = rob_q[open_q[n]].slot;
        wb_data[p]  = rand_bits(DATA_W);
        open_q.delete(n);
      end
    end
    flush = 1'b0;
    if (flushes && rob_q.size() >= 3 && rand_bits(4) == 0) begin
      n         = int'(rand_bits(4)) % (rob_q.size() - 1);
      flush     = 1'b1;
      flush_idx = rob_q[n].slot;
    end
  endtask

  always @(posedge clock) begin
    if (reset_n) begin
      model_step();
      checks_on = 1'b1;
    end
  end

  always @(negedge clock) begin
    if (checks_on) begin
      compare_outputs();
    end
  end

  initial begin
    int phase;
    lfsr         = 32'hdb81;
    checks       = 0;
    errors       = 0;
    checks_on    = 1'b0;
    bundle_taken = 1'b0;
    tail_slot    = '0;
    reset_n      = 1'b0;
    disp_valid   = 1'b0;
    disp_count   = 1'b0;
    flush        = 1'b0;
    flush_idx    = '0;
    for (int r = 0; r < 2**REG_IDX_W; r++) begin
      creg[r] = '0;
    end
    for (int i = 0; i < DISP_WIDTH; i++) begin
      disp_dest[i]       = '0;
      disp_dest_valid[i] = 1'b0;
      disp_srca[i]       = '0;
      disp_srcb[i]       = '0;
      exp_issue_valid[i] = 1'b0;
    end
    for (int p = 0; p < WB_PORTS; p++) begin
      wb_valid[p] = 1'b0;
      wb_slot[p]  = '0;
      wb_data[p]  = '0;
    end
    for (int i = 0; i < RET_WIDTH; i++) begin
      exp_ret_valid[i] = 1'b0;
    end
    repeat (3) @(negedge clock);
    // Outputs while reset is still held
    compare_outputs();
    reset_n = 1'b1;
    // Phases: steady flow, rob filling up, flushes
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      phase = (cyc / PHASE_LEN) % 3;
      drive_inputs(1'b1, phase == 2, (phase == 1) ? 1 : ((phase == 2) ? 4 : 5));
      @(negedge clock);
    end
    while (rob_q.size() != 0 || disp_valid) begin
      drive_inputs(1'b0, 1'b0, 8);
      @(negedge clock);
    end
    drive_inputs(1'b0, 1'b0, 0);
    repeat (3) @(negedge clock);
    for (int r = 0; r < 2**REG_IDX_W; r++) begin
      check_value($sformatf("regs[%0d]", r), u_dut.u_arch_regfile.regs[r], creg[r]);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #((3 + NUM_CYCLES + MARGIN) * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", 3 + NUM_CYCLES + MARGIN);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* flist.f */
hdl/rob_pkg.sv
hdl/dispatch_stage.sv
hdl/rob.sv
hdl/retire_stage.sv
hdl/arch_regfile.sv
hdl/rob_core_top.sv
sim/rob_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb \
  -Mdir obj_dir -f flist.f

out=$(./obj_dir/Vrob_tb 2>&1 || true)
echo "$out"
echo "$out" | grep -qx "RESULT: PASS"
